/* include/map_dec_params.svh */
// widths, state count and stack depth of the max-log-MAP decoder, included by RTL and testbench
`ifndef MAP_DEC_PARAMS_SVH
`define MAP_DEC_PARAMS_SVH

//----------------------------------------
// channel and metric widths
//----------------------------------------

// soft channel value, two's complement
`define MAP_LLR_W 6

// one state metric, also the a-posteriori LLR
`define MAP_METRIC_W 10

//----------------------------------------
// trellis and block size
//----------------------------------------

// 4-state RSC, feedback 7, feedforward 5
`define MAP_STATES 4

// stack address, word 0 unused so 63 symbols max
`define MAP_ADDR_W 6

`endif

/* src/map_dec_pkg.sv */
// shared types and metric helpers of the max-log-MAP decoder, imported by every RTL module
`default_nettype none

`include "map_dec_params.svh"

package map_dec_pkg;

  //----------------------------------------
  // vector types
  //----------------------------------------

  typedef logic signed [`MAP_LLR_W-1:0]              llr_t;
  typedef logic signed [`MAP_METRIC_W-1:0]           metric_t;
  // state 0 in the lowest slice
  typedef logic [`MAP_STATES*`MAP_METRIC_W-1:0]      metric_vec_t;
  // systematic in the upper half, parity below
  typedef logic [2*`MAP_LLR_W-1:0]                   chan_pair_t;
  typedef logic [`MAP_ADDR_W-1:0]                    sym_cnt_t;
  // wide sum of alpha, gamma and beta, no overflow
  typedef logic signed [`MAP_METRIC_W+2:0]           acc_t;

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_FWD,
    ST_BWD
  } ctrl_state_t;

  localparam int METRIC_MAX = 2**(`MAP_METRIC_W-1) - 1;
  localparam int METRIC_MIN = -(2**(`MAP_METRIC_W-1));

  //----------------------------------------
  // helpers
  //----------------------------------------

  // gamma of one transition, LLR signed by the bit it stands for
  function automatic acc_t branch_metric(llr_t sys, llr_t par, logic u, logic p);
    acc_t s_term;
    acc_t p_term;
    s_term = u ? acc_t'(sys) : -acc_t'(sys);
    p_term = p ? acc_t'(par) : -acc_t'(par);
    return s_term + p_term;
  endfunction

  function automatic acc_t max2(acc_t x, acc_t y);
    return (x > y) ? x : y;
  endfunction

  // clip a wide sum back into metric range
  function automatic metric_t sat_metric(acc_t v);
    if (v > acc_t'(METRIC_MAX)) begin
      return metric_t'(METRIC_MAX);
    end
    if (v < acc_t'(METRIC_MIN)) begin
      return metric_t'(METRIC_MIN);
    end
    return metric_t'(v);
  endfunction

  // one state out of a packed vector, sign extended
  function automatic acc_t get_metric(metric_vec_t v, int idx);
    return acc_t'(metric_t'(v[idx*`MAP_METRIC_W +: `MAP_METRIC_W]));
  endfunction

endpackage

`default_nettype wire

/* src/smm_if.sv */
// push/pop bundle of one LIFO stack, shared by the forward pass, the controller and the backward pass
`default_nettype none

interface smm_if #(
  parameter int data_w = 8
);

  // push side, written by the forward recursion
  logic              push;
  logic [data_w-1:0] wdata;
  // pop side, strobe from controller and data to backward recursion
  logic              pop;
  logic [data_w-1:0] rdata;

  modport push_mp (output push, output wdata);
  modport pop_mp  (input rdata);
  modport ctl     (output pop);
  modport mem     (input push, input wdata, input pop, output rdata);

endinterface

`default_nettype wire

/* src/map_dec_state_mem.sv */
// LIFO stack in a RAM array with one-cycle read latency, holds metrics or channel pairs per symbol
`default_nettype none

module map_dec_state_mem #(
  parameter int data_w = 40,
  parameter int addr_w = 6
) (
  input  logic iclk,
  input  logic ireset,
  input  logic clkena,
  smm_if.mem   stk
);

  //----------------------------------------
  // stack pointer
  //----------------------------------------

  // points at the top word, zero when empty
  logic [addr_w-1:0] ptr;
  // pre-increment, first word lands at address one
  logic [addr_w-1:0] waddr;
  logic [addr_w-1:0] raddr;
  logic [data_w-1:0] ram [2**addr_w];

  assign waddr = ptr + 1'b1;

  always_ff @(posedge iclk or posedge ireset) begin
    if (ireset) begin
      ptr <= '0;
    end else if (clkena) begin
      if (stk.push) begin
        ptr <= waddr;
      end else if (stk.pop) begin
        // post-decrement after the top is latched
        ptr <= ptr - 1'b1;
      end
    end
  end

  //----------------------------------------
  // array and registered read address
  //----------------------------------------

  always_ff @(posedge iclk) begin
    if (clkena) begin
      if (stk.push) begin
        ram[waddr] <= stk.wdata;
      end
      if (stk.pop) begin
        raddr <= ptr;
      end
    end
  end

  // popped word shows up one cycle after the pop strobe
  assign stk.rdata = ram[raddr];

  // forward pass and controller never share a cycle on one stack
  a_no_push_pop : assert property (@(posedge iclk) disable iff (ireset)
    !(stk.push && stk.pop));

  // controller pops exactly what was pushed
  a_no_pop_empty : assert property (@(posedge iclk) disable iff (ireset)
    (clkena && stk.pop) |-> (ptr != '0));

endmodule

`default_nettype wire

/* src/map_dec_fwd.sv */
// forward alpha recursion, pushes each symbol's alpha vector and channel pair onto the stacks
`default_nettype none

`include "map_dec_params.svh"

module map_dec_fwd import map_dec_pkg::*; (
  input  logic  iclk,
  input  logic  ireset,
  input  logic  accept,
  input  logic  first,
  input  llr_t  sys_llr,
  input  llr_t  par_llr,
  smm_if.push_mp alpha_stk,
  smm_if.push_mp chan_stk
);

  // state 0 known, others at the floor
  localparam metric_vec_t START_VEC = {
    metric_t'(METRIC_MIN), metric_t'(METRIC_MIN), metric_t'(METRIC_MIN), metric_t'(0)
  };

  metric_vec_t alpha_q;
  metric_vec_t alpha_cur;
  metric_vec_t alpha_nxt;
  acc_t        g00;
  acc_t        g01;
  acc_t        g10;
  acc_t        g11;
  acc_t        a [`MAP_STATES];
  acc_t        n [`MAP_STATES];

  // restart the trellis on the first symbol of a block
  assign alpha_cur = first ? START_VEC : alpha_q;

  //----------------------------------------
  // push side
  //----------------------------------------

  // metric stored is alpha before this symbol
  assign alpha_stk.push  = accept;
  assign alpha_stk.wdata = alpha_cur;
  assign chan_stk.push   = accept;
  assign chan_stk.wdata  = {sys_llr, par_llr};

  //----------------------------------------
  // branch metrics, gUP
  //----------------------------------------

  assign g00 = branch_metric(sys_llr, par_llr, 1'b0, 1'b0);
  assign g01 = branch_metric(sys_llr, par_llr, 1'b0, 1'b1);
  assign g10 = branch_metric(sys_llr, par_llr, 1'b1, 1'b0);
  assign g11 = branch_metric(sys_llr, par_llr, 1'b1, 1'b1);

  // state {s1,s0}, next state {u^s1^s0, s1}
  always_comb begin
    for (int s = 0; s < `MAP_STATES; s++) begin
      a[s] = get_metric(alpha_cur, s);
    end
    // two incoming branches per state
    n[0] = max2(a[0] + g00, a[1] + g11);
    n[1] = max2(a[2] + g10, a[3] + g01);
    n[2] = max2(a[0] + g11, a[1] + g00);
    n[3] = max2(a[2] + g01, a[3] + g10);
    // keep state 0 at zero
    for (int s = 0; s < `MAP_STATES; s++) begin
      alpha_nxt[s*`MAP_METRIC_W +: `MAP_METRIC_W] = sat_metric(n[s] - n[0]);
    end
  end

  always_ff @(posedge iclk or posedge ireset) begin
    if (ireset) begin
      alpha_q <= START_VEC;
    end else if (accept) begin
      alpha_q <= alpha_nxt;
    end
  end

endmodule

`default_nettype wire

/* src/map_dec_bwd.sv */
// backward beta recursion and max-log LLR, emits one soft and hard decision per popped symbol
`default_nettype none

`include "map_dec_params.svh"

module map_dec_bwd import map_dec_pkg::*; (
  input  logic    iclk,
  input  logic    ireset,
  input  logic    beta_clr,
  input  logic    rd_valid,
  input  logic    rd_last,
  smm_if.pop_mp   alpha_stk,
  smm_if.pop_mp   chan_stk,
  output logic    dec_valid,
  output logic    dec_last,
  output logic    dec_bit,
  output metric_t dec_llr
);

  metric_vec_t alpha_v;
  chan_pair_t  chan;
  llr_t        sys;
  llr_t        par;
  metric_vec_t beta_q;
  metric_vec_t beta_nxt;
  acc_t        g00;
  acc_t        g01;
  acc_t        g10;
  acc_t        g11;
  acc_t        a  [`MAP_STATES];
  acc_t        b  [`MAP_STATES];
  acc_t        nb [`MAP_STATES];
  acc_t        m0;
  acc_t        m1;
  metric_t     llr;

  //----------------------------------------
  // popped stack words
  //----------------------------------------

  assign alpha_v = alpha_stk.rdata;
  assign chan    = chan_stk.rdata;
  assign sys     = llr_t'(chan[2*`MAP_LLR_W-1:`MAP_LLR_W]);
  assign par     = llr_t'(chan[`MAP_LLR_W-1:0]);

  assign g00 = branch_metric(sys, par, 1'b0, 1'b0);
  assign g01 = branch_metric(sys, par, 1'b0, 1'b1);
  assign g10 = branch_metric(sys, par, 1'b1, 1'b0);
  assign g11 = branch_metric(sys, par, 1'b1, 1'b1);

  //----------------------------------------
  // LLR and beta update
  //----------------------------------------

  always_comb begin
    for (int s = 0; s < `MAP_STATES; s++) begin
      a[s] = get_metric(alpha_v, s);
      b[s] = get_metric(beta_q, s);
    end
    // input one, transitions 0->2, 1->0, 2->1, 3->3
    m1 = max2(max2(a[0] + g11 + b[2], a[1] + g11 + b[0]),
              max2(a[2] + g10 + b[1], a[3] + g10 + b[3]));
    // input zero, transitions 0->0, 1->2, 2->3, 3->1
    m0 = max2(max2(a[0] + g00 + b[0], a[1] + g00 + b[2]),
              max2(a[2] + g01 + b[3], a[3] + g01 + b[1]));
    llr = sat_metric(m1 - m0);
    // beta of this symbol from the successor's beta
    nb[0] = max2(g00 + b[0], g11 + b[2]);
    nb[1] = max2(g00 + b[2], g11 + b[0]);
    nb[2] = max2(g01 + b[3], g10 + b[1]);
    nb[3] = max2(g01 + b[1], g10 + b[3]);
    for (int s = 0; s < `MAP_STATES; s++) begin
      beta_nxt[s*`MAP_METRIC_W +: `MAP_METRIC_W] = sat_metric(nb[s] - nb[0]);
    end
  end

  // uniform start, unterminated trellis
  always_ff @(posedge iclk or posedge ireset) begin
    if (ireset) begin
      beta_q <= '0;
    end else if (beta_clr) begin
      beta_q <= '0;
    end else if (rd_valid) begin
      beta_q <= beta_nxt;
    end
  end

  //----------------------------------------
  // output register
  //----------------------------------------

  always_ff @(posedge iclk or posedge ireset) begin
    if (ireset) begin
      dec_valid <= 1'b0;
      dec_last  <= 1'b0;
    end else begin
      dec_valid <= rd_valid;
      dec_last  <= rd_last;
    end
  end

  // payload only
  always_ff @(posedge iclk) begin
    if (rd_valid) begin
      dec_llr <= llr;
      dec_bit <= (llr > 0);
    end
  end

  // last flag from controller must sit on a live read
  a_last_valid : assert property (@(posedge iclk) disable iff (ireset)
    dec_last |-> dec_valid);

endmodule

`default_nettype wire

/* src/map_dec_ctrl.sv */
// block controller, accepts symbols, counts them and sequences the pops of the backward pass
`default_nettype none

module map_dec_ctrl import map_dec_pkg::*; (
  input  logic iclk,
  input  logic ireset,
  input  logic sym_valid,
  input  logic sym_last,
  output logic accept,
  output logic first,
  output logic beta_clr,
  output logic rd_valid,
  output logic rd_last,
  output logic clkena,
  output logic busy,
  smm_if.ctl   alpha_pop,
  smm_if.ctl   chan_pop
);

  ctrl_state_t state;
  sym_cnt_t    cnt;
  logic        pop;
  // rd_last one cycle on, lines up with the output register
  logic        last_q;

  //----------------------------------------
  // strobes
  //----------------------------------------

  assign busy     = (state == ST_BWD);
  // dropped while the backward pass runs
  assign accept   = sym_valid && !busy;
  assign first    = accept && (state == ST_IDLE);
  assign beta_clr = accept && sym_last;
  // one pop per cycle until the count drains
  assign pop      = busy && (cnt != '0);
  // stacks only move on a push or a pop
  assign clkena   = accept || pop;

  assign alpha_pop.pop = pop;
  assign chan_pop.pop  = pop;

  //----------------------------------------
  // FSM and symbol counter
  //----------------------------------------

  always_ff @(posedge iclk or posedge ireset) begin
    if (ireset) begin
      state    <= ST_IDLE;
      cnt      <= '0;
      rd_valid <= 1'b0;
      rd_last  <= 1'b0;
      last_q   <= 1'b0;
    end else begin
      rd_valid <= pop;
      rd_last  <= pop && (cnt == sym_cnt_t'(1));
      last_q   <= rd_last;
      case (state)
        ST_IDLE, ST_FWD : begin
          if (accept) begin
            cnt   <= first ? sym_cnt_t'(1) : cnt + 1'b1;
            state <= sym_last ? ST_BWD : ST_FWD;
          end
        end
        ST_BWD : begin
          if (pop) begin
            cnt <= cnt - 1'b1;
          end
          // drop busy the cycle after dec_last
          if (last_q) begin
            state <= ST_IDLE;
          end
        end
        default : state <= ST_IDLE;
      endcase
    end
  end

  // no block longer than the stack
  a_cnt_max : assert property (@(posedge iclk) disable iff (ireset)
    (accept && !first) |-> (cnt != '1));

endmodule

`default_nettype wire

/* src/map_dec_top.sv */
// top level of the max-log-MAP decoder, streams soft channel values in and decisions out
`default_nettype none

`include "map_dec_params.svh"

module map_dec_top import map_dec_pkg::*; (
  input  logic    iclk,
  input  logic    ireset,
  input  logic    sym_valid,
  input  logic    sym_last,
  input  llr_t    sys_llr,
  input  llr_t    par_llr,
  output logic    busy,
  output logic    dec_valid,
  output logic    dec_last,
  output metric_t dec_llr,
  output logic    dec_bit
);

  logic accept;
  logic first;
  logic beta_clr;
  logic rd_valid;
  logic rd_last;
  logic clkena;

  //----------------------------------------
  // stacks
  //----------------------------------------

  smm_if #(.data_w($bits(metric_vec_t))) alpha_stk ();
  smm_if #(.data_w($bits(chan_pair_t)))  chan_stk ();

  map_dec_state_mem #(
    .data_w ($bits(metric_vec_t)),
    .addr_w (`MAP_ADDR_W)
  ) i_alpha_mem (
    .iclk   (iclk),
    .ireset (ireset),
    .clkena (clkena),
    .stk    (alpha_stk)
  );

  map_dec_state_mem #(
    .data_w ($bits(chan_pair_t)),
    .addr_w (`MAP_ADDR_W)
  ) i_chan_mem (
    .iclk   (iclk),
    .ireset (ireset),
    .clkena (clkena),
    .stk    (chan_stk)
  );

  //----------------------------------------
  // recursions and controller
  //----------------------------------------

  map_dec_fwd i_fwd (
    .iclk      (iclk),
    .ireset    (ireset),
    .accept    (accept),
    .first     (first),
    .sys_llr   (sys_llr),
    .par_llr   (par_llr),
    .alpha_stk (alpha_stk),
    .chan_stk  (chan_stk)
  );

  map_dec_bwd i_bwd (
    .iclk      (iclk),
    .ireset    (ireset),
    .beta_clr  (beta_clr),
    .rd_valid  (rd_valid),
    .rd_last   (rd_last),
    .alpha_stk (alpha_stk),
    .chan_stk  (chan_stk),
    .dec_valid (dec_valid),
    .dec_last  (dec_last),
    .dec_bit   (dec_bit),
    .dec_llr   (dec_llr)
  );

  map_dec_ctrl i_ctrl (
    .iclk      (iclk),
    .ireset    (ireset),
    .sym_valid (sym_valid),
    .sym_last  (sym_last),
    .accept    (accept),
    .first     (first),
    .beta_clr  (beta_clr),
    .rd_valid  (rd_valid),
    .rd_last   (rd_last),
    .clkena    (clkena),
    .busy      (busy),
    .alpha_pop (alpha_stk),
    .chan_pop  (chan_stk)
  );

endmodule

`default_nettype wire

/* tb/tb_map_dec.sv */
// simulation top that drives noiseless blocks into the MAP decoder and checks them by assertion
`default_nettype none

`include "map_dec_params.svh"

module tb_map_dec;

  localparam int N_BLOCKS    = 40;
  // longest block at up to three cycles per symbol plus slack
  localparam int TIMEOUT_CYC = N_BLOCKS * 63 * 3 + 500;
  localparam logic [31:0] SEED = 32'h3246_a5a7;
  localparam logic signed [`MAP_LLR_W-1:0] LLR_AMP = 20;

  logic                            iclk = 1'b0;
  logic                            ireset;
  logic                            sym_valid;
  logic                            sym_last;
  logic signed [`MAP_LLR_W-1:0]    sys_llr;
  logic signed [`MAP_LLR_W-1:0]    par_llr;
  logic                            busy;
  logic                            dec_valid;
  logic                            dec_last;
  logic signed [`MAP_METRIC_W-1:0] dec_llr;
  logic                            dec_bit;

  // scoreboard state
  logic [31:0] rng;
  logic [63:0] exp_bits;
  int          blk_len;
  int          out_cnt;
  int          exp_idx;
  logic        exp_bit;
  // high while the real last symbol of a block is on the inputs
  logic        last_sent;
  // sent sym_last delayed by three cycles
  logic [2:0]  last_sr;
  logic        more_q;
  logic        last_q;
  logic        in_out;
  logic        enc_s1;
  logic        enc_s0;
  int          errors  = 0;
  int          outputs = 0;
  int          dropped = 0;
  int          cyc     = 0;

  map_dec_top i_dut (
    .iclk      (iclk),
    .ireset    (ireset),
    .sym_valid (sym_valid),
    .sym_last  (sym_last),
    .sys_llr   (sys_llr),
    .par_llr   (par_llr),
    .busy      (busy),
    .dec_valid (dec_valid),
    .dec_last  (dec_last),
    .dec_llr   (dec_llr),
    .dec_bit   (dec_bit)
  );

  always #10 iclk = ~iclk;

  //----------------------------------------
  // helpers
  //----------------------------------------

  // 32-bit LCG returning a value in 0..modulus-1
  function automatic int next_rand(input int modulus);
    rng = rng * 32'd1664525 + 32'd1013904223;
    return int'(rng[30:16]) % modulus;
  endfunction

  // RSC 7/5 reference encoder that returns parity and advances state
  function automatic logic encode_parity(input logic u);
    logic fb;
    logic p;
    fb     = u ^ enc_s1 ^ enc_s0;
    p      = fb ^ enc_s0;
    enc_s0 = enc_s1;
    enc_s1 = fb;
    return p;
  endfunction

  task automatic report_mismatch(input string name, input int expected, input int actual);
    errors++;
    $display("[FAIL] %s at cycle %0d: expected %0d, actual %0d", name, cyc, expected, actual);
  endtask

  task automatic report_event(input string what);
    errors++;
    $display("error at cycle %0d: %s", cyc, what);
  endtask

  // inputs change a little after the rising edge
  task automatic next_cycle();
    @(posedge iclk);
    #2;
  endtask

  task automatic drive_idle();
    sym_valid = 1'b0;
    sym_last  = 1'b0;
    sys_llr   = '0;
    par_llr   = '0;
    last_sent = 1'b0;
  endtask

  // one noiseless symbol with each bit mapped to plus or minus the amplitude
  task automatic send_symbol(input int idx, input logic last, input logic zero_par);
    logic u;
    logic p;
    u             = (next_rand(2) == 1);
    p             = encode_parity(u);
    exp_bits[idx] = u;
    sym_valid     = 1'b1;
    sym_last      = last;
    last_sent     = last;
    sys_llr       = u ? LLR_AMP : -LLR_AMP;
    par_llr       = zero_par ? '0 : (p ? LLR_AMP : -LLR_AMP);
    next_cycle();
  endtask

  task automatic run_block(input int len, input logic zero_par);
    enc_s1  = 1'b0;
    enc_s0  = 1'b0;
    blk_len = len;
    for (int i = 0; i < len; i++) begin
      // random idle gaps between strobes
      while (next_rand(4) == 0) begin
        drive_idle();
        next_cycle();
      end
      send_symbol(i, i == len - 1, zero_par);
    end
    // junk strobes during the backward pass that must all be dropped
    while (busy) begin
      if (next_rand(2) == 1) begin
        sym_valid = 1'b1;
        sym_last  = (next_rand(2) == 1);
        sys_llr   = (`MAP_LLR_W)'(next_rand(63) - 31);
        par_llr   = (`MAP_LLR_W)'(next_rand(63) - 31);
        last_sent = 1'b0;
        dropped++;
      end else begin
        drive_idle();
      end
      next_cycle();
    end
    drive_idle();
  endtask

  //----------------------------------------
  // stimulus
  //----------------------------------------

  initial begin
    int len;
    rng      = SEED;
    exp_bits = '0;
    blk_len  = 1;
    enc_s1   = 1'b0;
    enc_s0   = 1'b0;
    ireset   = 1'b1;
    drive_idle();
    repeat (16) @(posedge iclk);
    #2;
    ireset = 1'b0;
    next_cycle();
    for (int b = 0; b < N_BLOCKS; b++) begin
      // block 0 shortest and block 1 longest
      if (b == 0) begin
        len = 1;
      end else if (b == 1) begin
        len = 63;
      end else begin
        len = 1 + next_rand(63);
      end
      // every fifth block without parity
      run_block(len, b % 5 == 4);
    end
    repeat (4) next_cycle();
    $display("blocks %0d, outputs %0d, dropped strobes %0d, errors %0d",
             N_BLOCKS, outputs, dropped, errors);
    if (errors == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

  always @(posedge iclk) begin
    cyc <= cyc + 1;
    if (cyc >= TIMEOUT_CYC) begin
      $display("timeout: decoder did not finish within %0d cycles", TIMEOUT_CYC);
      $display("Checks failed");
      $finish;
    end
  end

  //----------------------------------------
  // scoreboard
  //----------------------------------------

  // outputs come newest first
  assign exp_idx = blk_len - 1 - out_cnt;
  assign exp_bit = exp_bits[exp_idx[5:0]];

  always @(posedge iclk or posedge ireset) begin
    if (ireset) begin
      out_cnt <= 0;
      last_sr <= '0;
      more_q  <= 1'b0;
      last_q  <= 1'b0;
      in_out  <= 1'b0;
    end else begin
      last_sr <= {last_sr[1:0], last_sent};
      more_q  <= dec_valid && !dec_last;
      last_q  <= dec_last;
      if (last_sr[2]) begin
        in_out <= 1'b1;
      end
      if (dec_last) begin
        in_out <= 1'b0;
      end
      if (dec_valid) begin
        out_cnt <= dec_last ? 0 : out_cnt + 1;
        outputs <= outputs + 1;
      end
    end
  end

  a_reset_quiet : assert property (@(posedge iclk)
    ireset |-> (!busy && !dec_valid && !dec_last))
    else report_event("outputs not quiet during reset");

  a_dec_bit : assert property (@(posedge iclk) disable iff (ireset)
    (dec_valid && out_cnt < blk_len) |-> (dec_bit == exp_bit))
    else report_mismatch("dec_bit", $sampled(exp_bit), $sampled(dec_bit));

  a_llr_nonzero : assert property (@(posedge iclk) disable iff (ireset)
    dec_valid |-> (dec_llr != 0))
    else report_event("dec_llr is zero on a noiseless symbol");

  a_llr_sign : assert property (@(posedge iclk) disable iff (ireset)
    (dec_valid && out_cnt < blk_len) |-> ((dec_llr > 0) == exp_bit))
    else report_mismatch("dec_llr_positive", $sampled(exp_bit), $sampled(dec_llr) > 0);

  a_count : assert property (@(posedge iclk) disable iff (ireset)
    dec_valid |-> (out_cnt < blk_len))
    else report_event("more outputs than symbols in the block");

  a_last_pos : assert property (@(posedge iclk) disable iff (ireset)
    dec_valid |-> (dec_last == (out_cnt == blk_len - 1)))
    else report_mismatch("dec_last", $sampled(out_cnt) == $sampled(blk_len) - 1,
                         $sampled(dec_last));

  // three cycles from accepted sym_last to first output
  a_first_lat : assert property (@(posedge iclk) disable iff (ireset)
    last_sr[2] |-> (dec_valid && out_cnt == 0))
    else report_event("first output not 3 cycles after sym_last");

  a_window : assert property (@(posedge iclk) disable iff (ireset)
    dec_valid |-> (in_out || last_sr[2]))
    else report_event("dec_valid outside the output burst");

  a_consec : assert property (@(posedge iclk) disable iff (ireset)
    more_q |-> dec_valid)
    else report_event("gap inside the output burst");

  a_busy_hold : assert property (@(posedge iclk) disable iff (ireset)
    dec_valid |-> busy)
    else report_event("busy low during an output");

  a_busy_fall : assert property (@(posedge iclk) disable iff (ireset)
    last_q |-> !busy)
    else report_event("busy still high the cycle after dec_last");

endmodule

`default_nettype wire

/* vlog.f */
+incdir+include
src/map_dec_pkg.sv
src/smm_if.sv
src/map_dec_state_mem.sv
src/map_dec_fwd.sv
src/map_dec_bwd.sv
src/map_dec_ctrl.sv
src/map_dec_top.sv
tb/tb_map_dec.sv

/* Makefile */
# Verilator build and run of the max-log-MAP decoder testbench

VERILATOR ?= verilator
TOP       ?= tb_map_dec
FILELIST  ?= vlog.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  ?= All checks passed

.PHONY: sim clean

# the run passes only if the pass line shows up in the output
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qxF "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
